//--- design/cpu_pkg.sv
// Shared widths, opcodes, ALU and branch codes, and the instruction-word view for the core
package cpu_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // ------------------------------
    // RV32I opcodes handled here
    // ------------------------------
    localparam logic [6:0] op_rtype     = 7'b0110011;
    localparam logic [6:0] op_itype_alu = 7'b0010011;
    localparam logic [6:0] op_branch    = 7'b1100011;

    // ALU operations, shared by decode, ALU and execute
    localparam logic [3:0] alu_add  = 4'd0;
    localparam logic [3:0] alu_sub  = 4'd1;
    localparam logic [3:0] alu_sll  = 4'd2;
    localparam logic [3:0] alu_slt  = 4'd3;
    localparam logic [3:0] alu_sltu = 4'd4;
    localparam logic [3:0] alu_xor  = 4'd5;
    localparam logic [3:0] alu_srl  = 4'd6;
    localparam logic [3:0] alu_sra  = 4'd7;
    localparam logic [3:0] alu_or   = 4'd8;
    localparam logic [3:0] alu_and  = 4'd9;

    // Branch kinds resolved in execute
    localparam logic [1:0] br_none = 2'd0;
    localparam logic [1:0] br_beq  = 2'd1;
    localparam logic [1:0] br_bne  = 2'd2;

    // ------------------------------
    // Instruction word, three views
    // ------------------------------
    // Register fields sit at the same bits in every view
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } i;
        struct packed {
            logic                  imm12;
            logic [5:0]            imm10_5;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [3:0]            imm4_1;
            logic                  imm11;
            logic [6:0]            opcode;
        } b;
    } instr_word_u;

endpackage

//--- design/alu.sv
// Combinational ALU of the core, instantiated by the execute stage
`timescale 1ns/1ps

module alu (
    input  logic [3:0]               alu_op,
    input  logic [cpu_pkg::xlen-1:0] operand_a,
    input  logic [cpu_pkg::xlen-1:0] operand_b,
    output logic [cpu_pkg::xlen-1:0] result
);

    logic [4:0] shamt;

    // Shift amount from low bits only
    assign shamt = operand_b[4:0];

    always_comb begin
        case (alu_op)
            cpu_pkg::alu_add:  result = operand_a + operand_b;
            cpu_pkg::alu_sub:  result = operand_a - operand_b;
            cpu_pkg::alu_sll:  result = operand_a << shamt;
            // Compares give 1 or 0
            cpu_pkg::alu_slt:  result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            cpu_pkg::alu_sltu: result = {31'b0, operand_a < operand_b};
            cpu_pkg::alu_xor:  result = operand_a ^ operand_b;
            cpu_pkg::alu_srl:  result = operand_a >> shamt;
            cpu_pkg::alu_sra:  result = $unsigned($signed(operand_a) >>> shamt);
            cpu_pkg::alu_or:   result = operand_a | operand_b;
            cpu_pkg::alu_and:  result = operand_a & operand_b;
            default:           result = '0;
        endcase
    end

endmodule

//--- design/register_file.sv
// Integer register file of the core, two read ports with write-through, one write port
`timescale 1ns/1ps

module register_file (
    input  logic                           clk,
    input  logic [cpu_pkg::reg_addr_w-1:0] read_reg1,
    input  logic [cpu_pkg::reg_addr_w-1:0] read_reg2,
    input  logic                           write_enable,
    input  logic [cpu_pkg::reg_addr_w-1:0] write_reg,
    input  logic [cpu_pkg::xlen-1:0]       write_data,
    output logic [cpu_pkg::xlen-1:0]       read_data1,
    output logic [cpu_pkg::xlen-1:0]       read_data2
);

    logic [cpu_pkg::xlen-1:0] regs [32];

    // Registers start at zero
    initial begin
        for (int idx = 0; idx < 32; idx++) begin
            regs[idx] = '0;
        end
    end

    // x0 is never written
    always @(posedge clk) begin
        if (write_enable && write_reg != '0) begin
            regs[write_reg] <= write_data;
        end
    end

    // Same-cycle write shows on the read, closes the distance-two hazard
    assign read_data1 = (read_reg1 == '0) ? '0 :
                        (write_enable && write_reg == read_reg1) ? write_data :
                        regs[read_reg1];
    assign read_data2 = (read_reg2 == '0) ? '0 :
                        (write_enable && write_reg == read_reg2) ? write_data :
                        regs[read_reg2];

endmodule

//--- design/fetch_unit.sv
// Fetch stage of the core: PC, branch redirect and the fetch/decode register
`timescale 1ns/1ps

module fetch_unit (
    input  logic                     clk,
    input  logic                     exmem_reset,
    input  logic [cpu_pkg::xlen-1:0] imem_data,
    input  logic                     redirect,
    input  logic [cpu_pkg::xlen-1:0] redirect_target,
    output logic [cpu_pkg::xlen-1:0] imem_addr,
    output logic [cpu_pkg::xlen-1:0] if_pc,
    output logic [cpu_pkg::xlen-1:0] if_instr,
    output logic                     if_valid
);

    logic [cpu_pkg::xlen-1:0] pc;
    logic [cpu_pkg::xlen-1:0] pc_next;

    // Memory answers in the same cycle
    assign imem_addr = pc;

    // Taken branch wins over sequential fetch
    assign pc_next = redirect ? redirect_target : pc + cpu_pkg::xlen'(4);

    // ------------------------------
    // Program counter
    // ------------------------------
    always_ff @(posedge clk) begin
        if (exmem_reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // ------------------------------
    // Fetch/decode register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (exmem_reset) begin
            if_valid <= 1'b0;
        end else begin
            // Word fetched under a redirect is the younger one, drop it
            if_valid <= ~redirect;
        end
    end

    // Payload, qualified by if_valid
    always_ff @(posedge clk) begin
        if_pc    <= pc;
        if_instr <= imem_data;
    end

endmodule

//--- design/decode_unit.sv
// Decode stage of the core: control decode, immediates, register read, decode/execute register
`timescale 1ns/1ps

module decode_unit (
    input  logic                           clk,
    input  logic                           exmem_reset,
    input  logic [cpu_pkg::xlen-1:0]       if_pc,
    input  logic [cpu_pkg::xlen-1:0]       if_instr,
    input  logic                           if_valid,
    input  logic                           redirect,
    input  logic                           wb_write,
    input  logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [cpu_pkg::xlen-1:0]       wb_data,
    output logic                           id_valid,
    output logic [cpu_pkg::xlen-1:0]       id_pc,
    output logic [cpu_pkg::reg_addr_w-1:0] id_rs1,
    output logic [cpu_pkg::reg_addr_w-1:0] id_rs2,
    output logic [cpu_pkg::reg_addr_w-1:0] id_rd,
    output logic [cpu_pkg::xlen-1:0]       id_rs1_data,
    output logic [cpu_pkg::xlen-1:0]       id_rs2_data,
    output logic [cpu_pkg::xlen-1:0]       id_imm,
    output logic [3:0]                     id_alu_op,
    output logic                           id_alu_src,
    output logic                           id_reg_write,
    output logic [1:0]                     id_branch_op
);

    cpu_pkg::instr_word_u     instr;
    logic [cpu_pkg::xlen-1:0] rs1_data;
    logic [cpu_pkg::xlen-1:0] rs2_data;
    logic [cpu_pkg::xlen-1:0] imm_i;
    logic [cpu_pkg::xlen-1:0] imm_b;

    // Decoded controls, before the register
    logic [3:0]               dec_alu_op;
    logic                     dec_alu_src;
    logic                     dec_reg_write;
    logic [1:0]               dec_branch_op;
    logic [cpu_pkg::xlen-1:0] dec_imm;

    assign instr = if_instr;

    // Writes come back from the execute/writeback register
    register_file u_regfile (
        .clk          (clk),
        .read_reg1    (instr.r.rs1),
        .read_reg2    (instr.r.rs2),
        .write_enable (wb_write),
        .write_reg    (wb_rd),
        .write_data   (wb_data),
        .read_data1   (rs1_data),
        .read_data2   (rs2_data)
    );

    // ------------------------------
    // Immediates
    // ------------------------------
    assign imm_i = {{20{instr.i.imm12[11]}}, instr.i.imm12};
    // B offset is even, bit 0 implied
    assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};

    // ------------------------------
    // Control decode
    // ------------------------------
    always_comb begin
        // No-op unless recognised
        dec_alu_op    = cpu_pkg::alu_add;
        dec_alu_src   = 1'b0;
        dec_reg_write = 1'b0;
        dec_branch_op = cpu_pkg::br_none;
        dec_imm       = imm_i;

        case (instr.r.opcode)
            cpu_pkg::op_rtype: begin
                dec_reg_write = 1'b1;
                case (instr.r.funct3)
                    3'b000: dec_alu_op = instr.r.funct7[5] ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
                    3'b001: dec_alu_op = cpu_pkg::alu_sll;
                    3'b010: dec_alu_op = cpu_pkg::alu_slt;
                    3'b011: dec_alu_op = cpu_pkg::alu_sltu;
                    3'b100: dec_alu_op = cpu_pkg::alu_xor;
                    3'b101: dec_alu_op = instr.r.funct7[5] ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
                    3'b110: dec_alu_op = cpu_pkg::alu_or;
                    default: dec_alu_op = cpu_pkg::alu_and;
                endcase
            end

            cpu_pkg::op_itype_alu: begin
                // Only ADDI, other I-type ALU ops stay no-ops
                if (instr.i.funct3 == 3'b000) begin
                    dec_reg_write = 1'b1;
                    dec_alu_src   = 1'b1;
                end
            end

            cpu_pkg::op_branch: begin
                dec_imm = imm_b;
                if (instr.b.funct3 == 3'b000) begin
                    dec_branch_op = cpu_pkg::br_beq;
                end else if (instr.b.funct3 == 3'b001) begin
                    dec_branch_op = cpu_pkg::br_bne;
                end
            end

            default: begin
            end
        endcase
    end

    // ------------------------------
    // Decode/execute register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (exmem_reset) begin
            id_valid     <= 1'b0;
            id_reg_write <= 1'b0;
            id_branch_op <= cpu_pkg::br_none;
        end else begin
            // Squashed when the branch in execute is taken
            id_valid     <= if_valid & ~redirect;
            id_reg_write <= dec_reg_write;
            id_branch_op <= dec_branch_op;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        id_pc       <= if_pc;
        id_rs1      <= instr.r.rs1;
        id_rs2      <= instr.r.rs2;
        id_rd       <= instr.r.rd;
        id_rs1_data <= rs1_data;
        id_rs2_data <= rs2_data;
        id_imm      <= dec_imm;
        id_alu_op   <= dec_alu_op;
        id_alu_src  <= dec_alu_src;
    end

endmodule

//--- design/execute_unit.sv
// Execute stage of the core: forwarding, ALU, branch decision and the execute/writeback register
`timescale 1ns/1ps

module execute_unit (
    input  logic                           clk,
    input  logic                           exmem_reset,
    input  logic                           id_valid,
    input  logic [cpu_pkg::xlen-1:0]       id_pc,
    input  logic [cpu_pkg::reg_addr_w-1:0] id_rs1,
    input  logic [cpu_pkg::reg_addr_w-1:0] id_rs2,
    input  logic [cpu_pkg::reg_addr_w-1:0] id_rd,
    input  logic [cpu_pkg::xlen-1:0]       id_rs1_data,
    input  logic [cpu_pkg::xlen-1:0]       id_rs2_data,
    input  logic [cpu_pkg::xlen-1:0]       id_imm,
    input  logic [3:0]                     id_alu_op,
    input  logic                           id_alu_src,
    input  logic                           id_reg_write,
    input  logic [1:0]                     id_branch_op,
    output logic                           redirect,
    output logic [cpu_pkg::xlen-1:0]       redirect_target,
    output logic                           wb_valid,
    output logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
    output logic [cpu_pkg::xlen-1:0]       wb_data
);

    logic [cpu_pkg::xlen-1:0] fwd_a;
    logic [cpu_pkg::xlen-1:0] fwd_b;
    logic [cpu_pkg::xlen-1:0] alu_b;
    logic [cpu_pkg::xlen-1:0] alu_result;
    logic                     operands_equal;

    // ------------------------------
    // Forwarding
    // ------------------------------
    // wb_valid already excludes x0, so no zero check needed here
    assign fwd_a = (wb_valid && wb_rd == id_rs1) ? wb_data : id_rs1_data;
    assign fwd_b = (wb_valid && wb_rd == id_rs2) ? wb_data : id_rs2_data;

    // Immediate for ADDI, register otherwise
    assign alu_b = id_alu_src ? id_imm : fwd_b;

    alu u_alu (
        .alu_op    (id_alu_op),
        .operand_a (fwd_a),
        .operand_b (alu_b),
        .result    (alu_result)
    );

    // ------------------------------
    // Branch resolution
    // ------------------------------
    assign operands_equal  = (fwd_a == fwd_b);
    assign redirect_target = id_pc + id_imm;

    always_comb begin
        redirect = 1'b0;
        if (id_valid) begin
            case (id_branch_op)
                cpu_pkg::br_beq: redirect = operands_equal;
                cpu_pkg::br_bne: redirect = ~operands_equal;
                default:         redirect = 1'b0;
            endcase
        end
    end

    // ------------------------------
    // Execute/writeback register
    // ------------------------------
    // Feeds regfile write, forwarding and retire port
    always_ff @(posedge clk) begin
        if (exmem_reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= id_valid & id_reg_write & (id_rd != '0);
        end
    end

    // Payload, qualified by wb_valid
    always_ff @(posedge clk) begin
        wb_rd   <= id_rd;
        wb_data <= alu_result;
    end

endmodule

//--- design/cpu_core.sv
// Top level of the four-stage RV32I subset core, instruction port in, retire port out
`timescale 1ns/1ps

module cpu_core (
    input  logic                           clk,
    input  logic                           exmem_reset,
    input  logic [cpu_pkg::xlen-1:0]       imem_data,
    output logic [cpu_pkg::xlen-1:0]       imem_addr,
    output logic                           wb_valid,
    output logic [cpu_pkg::reg_addr_w-1:0] wb_rd,
    output logic [cpu_pkg::xlen-1:0]       wb_data
);

    // Fetch to decode
    logic [cpu_pkg::xlen-1:0]       if_pc;
    logic [cpu_pkg::xlen-1:0]       if_instr;
    logic                           if_valid;

    // Decode to execute
    logic                           id_valid;
    logic [cpu_pkg::xlen-1:0]       id_pc;
    logic [cpu_pkg::reg_addr_w-1:0] id_rs1;
    logic [cpu_pkg::reg_addr_w-1:0] id_rs2;
    logic [cpu_pkg::reg_addr_w-1:0] id_rd;
    logic [cpu_pkg::xlen-1:0]       id_rs1_data;
    logic [cpu_pkg::xlen-1:0]       id_rs2_data;
    logic [cpu_pkg::xlen-1:0]       id_imm;
    logic [3:0]                     id_alu_op;
    logic                           id_alu_src;
    logic                           id_reg_write;
    logic [1:0]                     id_branch_op;

    // Branch redirect from execute
    logic                           redirect;
    logic [cpu_pkg::xlen-1:0]       redirect_target;

    fetch_unit u_fetch (
        .clk             (clk),
        .exmem_reset     (exmem_reset),
        .imem_data       (imem_data),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .imem_addr       (imem_addr),
        .if_pc           (if_pc),
        .if_instr        (if_instr),
        .if_valid        (if_valid)
    );

    // Retire port doubles as regfile write
    decode_unit u_decode (
        .clk          (clk),
        .exmem_reset  (exmem_reset),
        .if_pc        (if_pc),
        .if_instr     (if_instr),
        .if_valid     (if_valid),
        .redirect     (redirect),
        .wb_write     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .id_valid     (id_valid),
        .id_pc        (id_pc),
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .id_rd        (id_rd),
        .id_rs1_data  (id_rs1_data),
        .id_rs2_data  (id_rs2_data),
        .id_imm       (id_imm),
        .id_alu_op    (id_alu_op),
        .id_alu_src   (id_alu_src),
        .id_reg_write (id_reg_write),
        .id_branch_op (id_branch_op)
    );

    execute_unit u_execute (
        .clk             (clk),
        .exmem_reset     (exmem_reset),
        .id_valid        (id_valid),
        .id_pc           (id_pc),
        .id_rs1          (id_rs1),
        .id_rs2          (id_rs2),
        .id_rd           (id_rd),
        .id_rs1_data     (id_rs1_data),
        .id_rs2_data     (id_rs2_data),
        .id_imm          (id_imm),
        .id_alu_op       (id_alu_op),
        .id_alu_src      (id_alu_src),
        .id_reg_write    (id_reg_write),
        .id_branch_op    (id_branch_op),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .wb_valid        (wb_valid),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data)
    );

endmodule

//--- sim/tb_clock_gen.sv
// Testbench clock and reset source for the core, 8 ns clock and reset over the first 3 edges
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic exmem_reset
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held over three rising edges, released just after the third
    initial begin
        exmem_reset = 1'b1;
        repeat (3) @(posedge clk);
        #1 exmem_reset = 1'b0;
    end

endmodule

//--- sim/tb_cpu_core.sv
// Top-level testbench that runs a random program on cpu_core and checks each retire against a model
`timescale 1ns/1ps

module tb_cpu_core;

    localparam int prog_len    = 200;
    localparam int mem_words   = 256;
    localparam int quiet_limit = 20;
    localparam int max_cycles  = 4 * prog_len + 100;
    // ADDI x0, x0, 0
    localparam logic [31:0] nop_word = 32'h0000_0013;

    logic        clk;
    logic        exmem_reset;
    logic [31:0] imem_data;
    logic [31:0] imem_addr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    // Program image, expected retire list, model registers
    logic [31:0] prog_mem [mem_words];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_val_q [$];
    logic [31:0] model_regs [32];

    int          cycle_count;
    int          quiet_cycles;
    int          taken_count;
    logic        prev_reset;
    logic        reset_seen;
    logic        finished;

    tb_clock_gen u_clock_gen (
        .clk         (clk),
        .exmem_reset (exmem_reset)
    );

    cpu_core UUT (
        .clk         (clk),
        .exmem_reset (exmem_reset),
        .imem_data   (imem_data),
        .imem_addr   (imem_addr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    // ------------------------------
    // Instruction memory
    // ------------------------------
    // Combinational answer with a no-op outside the image
    always_comb begin
        if ($isunknown(imem_addr) || imem_addr[31:10] != 22'd0) begin
            imem_data = nop_word;
        end else begin
            imem_data = prog_mem[imem_addr[9:2]];
        end
    end

    // ------------------------------
    // Program encoding
    // ------------------------------
    function automatic logic [31:0] rand_below(logic [31:0] limit);
        return $urandom % limit;
    endfunction

    // Only x0 to x7 for dense dependencies
    function automatic logic [4:0] pick_reg();
        logic [31:0] draw;
        draw = $urandom;
        return {2'b00, draw[2:0]};
    endfunction

    function automatic logic [31:0] encode_rtype(logic [3:0] kind, logic [4:0] rd,
                                                 logic [4:0] rs1, logic [4:0] rs2);
        logic [6:0] funct7;
        logic [2:0] funct3;
        funct7 = 7'b0000000;
        case (kind)
            4'd0, 4'd1: funct3 = 3'd0;
            4'd2:       funct3 = 3'd1;
            4'd3:       funct3 = 3'd2;
            4'd4:       funct3 = 3'd3;
            4'd5:       funct3 = 3'd4;
            4'd6, 4'd7: funct3 = 3'd5;
            4'd8:       funct3 = 3'd6;
            default:    funct3 = 3'd7;
        endcase
        // SUB and SRA carry the alternate funct7
        if (kind == 4'd1 || kind == 4'd7) begin
            funct7 = 7'b0100000;
        end
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_addi(logic [11:0] imm, logic [4:0] rd,
                                                logic [4:0] rs1);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    // Offset scattered over the B format without bit 0
    function automatic logic [31:0] encode_branch(logic is_bne, logic [4:0] rs1,
                                                  logic [4:0] rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, {2'b00, is_bne}, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic build_program();
        logic [31:0] sel;
        logic [31:0] pick;
        logic [2:0]  skip;
        for (int i = 0; i < mem_words; i++) begin
            prog_mem[8'(i)] = nop_word;
        end
        for (int i = 0; i < prog_len; i++) begin
            sel = rand_below(32'd10);
            if (sel < 32'd6) begin
                pick = rand_below(32'd10);
                prog_mem[8'(i)] = encode_rtype(pick[3:0], pick_reg(), pick_reg(), pick_reg());
            end else if (sel < 32'd8) begin
                // Full 12-bit range including negatives
                pick = $urandom;
                prog_mem[8'(i)] = encode_addi(pick[11:0], pick_reg(), pick_reg());
            end else begin
                // Forward only by 1 to 4 instructions
                skip = 3'(rand_below(32'd4) + 32'd1);
                prog_mem[8'(i)] = encode_branch(sel == 32'd9, pick_reg(), pick_reg(),
                                                {8'b0, skip, 2'b00});
            end
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [31:0] rtype_result(logic [6:0] funct7, logic [2:0] funct3,
                                                 logic [31:0] a, logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (funct3)
            3'd0: return funct7[5] ? a - b : a + b;
            3'd1: return a << sh;
            // When signs differ the negative one is smaller
            3'd2: return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            // Arithmetic shift refills the top with the sign
            3'd5: return funct7[5] ? ((a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0))
                                   : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] word;
        logic [31:0] imm;
        logic [31:0] res;
        logic [31:0] src1;
        logic [31:0] src2;
        logic        write;
        for (int k = 0; k < 32; k++) begin
            model_regs[5'(k)] = '0;
        end
        pc          = '0;
        taken_count = 0;
        // Branches only go forward so this loop ends
        while (pc < 32'(4 * prog_len)) begin
            word    = prog_mem[pc[9:2]];
            src1    = model_regs[word[19:15]];
            src2    = model_regs[word[24:20]];
            next_pc = pc + 32'd4;
            write   = 1'b0;
            res     = '0;
            case (word[6:0])
                7'b0110011: begin
                    res   = rtype_result(word[31:25], word[14:12], src1, src2);
                    write = 1'b1;
                end
                7'b0010011: begin
                    imm   = {{20{word[31]}}, word[31:20]};
                    res   = src1 + imm;
                    write = (word[14:12] == 3'b000);
                end
                7'b1100011: begin
                    imm = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
                    if ((word[14:12] == 3'b000 && src1 == src2) ||
                        (word[14:12] == 3'b001 && src1 != src2)) begin
                        next_pc = pc + imm;
                        taken_count++;
                    end
                end
                default: begin
                end
            endcase
            // x0 stays zero and never retires
            if (write && word[11:7] != 5'd0) begin
                model_regs[word[11:7]] = res;
                exp_rd_q.push_back(word[11:7]);
                exp_val_q.push_back(res);
            end
            pc = next_pc;
        end
    endtask

    // ------------------------------
    // Checking
    // ------------------------------
    task automatic stop_with_failure();
        $display("Something failed");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic abort_run(input string why);
        $display("%s at %0t ns", why, $time);
        stop_with_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    // One rising edge with values seen before the edge updates
    task automatic sample_cycle();
        logic [4:0]  exp_rd;
        logic [31:0] exp_val;
        cycle_count++;
        if (cycle_count > max_cycles) begin
            abort_run($sformatf("Timeout with %0d retires still missing", exp_rd_q.size()));
        end
        // Reset and the first cycle out of it
        if (prev_reset) begin
            check_value("wb_valid", {31'b0, wb_valid}, 32'd0);
            check_value("imem_addr", imem_addr, 32'd0);
        end
        if (exmem_reset) begin
            reset_seen = 1'b1;
        end else if (reset_seen) begin
            if ($isunknown(wb_valid)) begin
                abort_run("Retire strobe is unknown after reset");
            end else if (wb_valid) begin
                if (exp_rd_q.size() == 0) begin
                    abort_run($sformatf("Extra retire to x%0d beyond the program", wb_rd));
                end else begin
                    exp_rd  = exp_rd_q.pop_front();
                    exp_val = exp_val_q.pop_front();
                    check_value("wb_rd", {27'b0, wb_rd}, {27'b0, exp_rd});
                    check_value("wb_data", wb_data, exp_val);
                    quiet_cycles = 0;
                end
            end else if (exp_rd_q.size() == 0) begin
                quiet_cycles++;
                if (quiet_cycles >= quiet_limit) begin
                    finished = 1'b1;
                end
            end
        end
        prev_reset = exmem_reset;
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        void'($urandom(50677));
        cycle_count  = 0;
        quiet_cycles = 0;
        prev_reset   = 1'b0;
        reset_seen   = 1'b0;
        finished     = 1'b0;
        build_program();
        run_model();
        $display("Program of %0d instructions, %0d writes and %0d taken branches in the model",
                 prog_len, exp_rd_q.size(), taken_count);
        while (!finished) begin
            @(posedge clk);
            sample_cycle();
        end
        $display("Everything OK");
        $finish;
    end

endmodule

//--- src.f
design/cpu_pkg.sv
design/alu.sv
design/register_file.sv
design/fetch_unit.sv
design/decode_unit.sv
design/execute_unit.sv
design/cpu_core.sv
sim/tb_clock_gen.sv
sim/tb_cpu_core.sv

//--- Makefile
# Verilator build and run of the cpu_core testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 -f src.f --top-module tb_cpu_core
	./obj_dir/Vtb_cpu_core

clean:
	rm -rf obj_dir
